//--- hw/lt_bus_fabric.sv
`timescale 1ns/1ps

module lt_bus_fabric (
    input  logic                        clk,
    input  logic                        rst_n,
    // cpu side
    input  logic                        i_enable,
    input  lt_pkg::cpu_req_t            i_req,
    output logic                        o_ready,
    output logic [lt_pkg::DATA_W-1:0]   o_rdata,
    output logic                        o_bus_err,
    // peripheral side
    output lt_pkg::per_req_t            o_per_req,
    output logic                        o_ram_en,
    output logic                        o_tmr_en,
    input  lt_pkg::per_rsp_t            i_ram_rsp,
    input  lt_pkg::per_rsp_t            i_tmr_rsp
);

    lt_pkg::fabric_state_e       state_q;
    lt_pkg::slot_e               req_slot;
    lt_pkg::slot_e               cur_slot;
    logic                        req_start;
    logic                        sel_ram;
    logic                        sel_tmr;
    logic                        mapped;
    logic                        mux_ready;
    logic                        mux_err;
    logic [lt_pkg::DATA_W-1:0]   mux_rdata;

    // ------------------------------------------------------------------
    // request capture
    // ------------------------------------------------------------------
    // new request only while idle and the last ready has been dropped
    assign req_start = (state_q == lt_pkg::FS_IDLE) && i_enable && !o_ready;
    assign req_slot  = lt_pkg::slot_e'(i_req.addr[lt_pkg::ADDR_W-1 -: lt_pkg::SLOT_W]);

    // payload only, valid from the capture edge on
    always_ff @(posedge clk) begin
        if (req_start) begin
            o_per_req.write <= i_req.write;
            o_per_req.offs  <= i_req.addr[lt_pkg::OFFS_W-1:0];
            o_per_req.wdata <= i_req.wdata;
            o_per_req.be    <= i_req.be;
            cur_slot        <= req_slot;
        end
    end

    // ------------------------------------------------------------------
    // slot decode and and-or response mux
    // ------------------------------------------------------------------
    always_comb begin
        sel_ram = 1'b0;
        sel_tmr = 1'b0;
        case (cur_slot)
            lt_pkg::SLOT_RAM:   sel_ram = 1'b1;
            lt_pkg::SLOT_TIMER: sel_tmr = 1'b1;
            // reserved slot, answered here with an error
            lt_pkg::SLOT_UART:  ;
            default:            ;
        endcase
    end

    assign mapped    = sel_ram || sel_tmr;
    assign mux_ready = (sel_ram & i_ram_rsp.ready) | (sel_tmr & i_tmr_rsp.ready);
    assign mux_err   = (sel_ram & i_ram_rsp.err) | (sel_tmr & i_tmr_rsp.err);
    assign mux_rdata = ({lt_pkg::DATA_W{sel_ram}} & i_ram_rsp.rdata)
                     | ({lt_pkg::DATA_W{sel_tmr}} & i_tmr_rsp.rdata);

    // ------------------------------------------------------------------
    // bus state machine
    // ------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q   <= lt_pkg::FS_IDLE;
            o_ready   <= 1'b0;
            o_rdata   <= '0;
            o_bus_err <= 1'b0;
            o_ram_en  <= 1'b0;
            o_tmr_en  <= 1'b0;
        end else begin
            case (state_q)
                lt_pkg::FS_IDLE: begin
                    if (req_start) begin
                        // one-hot enable, none for unmapped slots
                        o_ram_en <= (req_slot == lt_pkg::SLOT_RAM);
                        o_tmr_en <= (req_slot == lt_pkg::SLOT_TIMER);
                        state_q  <= lt_pkg::FS_WAIT;
                    end
                end
                lt_pkg::FS_WAIT: begin
                    if (!mapped) begin
                        // nobody home, answer right away
                        o_ready   <= 1'b1;
                        o_bus_err <= 1'b1;
                        o_rdata   <= '0;
                        state_q   <= lt_pkg::FS_IDLE;
                    end else if (mux_ready) begin
                        o_ready   <= 1'b1;
                        o_bus_err <= mux_err;
                        o_rdata   <= mux_rdata;
                        o_ram_en  <= 1'b0;
                        o_tmr_en  <= 1'b0;
                        state_q   <= lt_pkg::FS_IDLE;
                    end
                end
                default: state_q <= lt_pkg::FS_IDLE;
            endcase

            // cpu dropped enable, release the handshake
            if (!i_enable) begin
                o_ready   <= 1'b0;
                o_bus_err <= 1'b0;
                o_ram_en  <= 1'b0;
                o_tmr_en  <= 1'b0;
                state_q   <= lt_pkg::FS_IDLE;
            end
        end
    end

    // ------------------------------------------------------------------
    // checks
    // ------------------------------------------------------------------
    a_one_hot_en: assert property (@(posedge clk) disable iff (!rst_n)
        !(o_ram_en && o_tmr_en));

    // ready held only after the fsm went back to idle
    a_ready_idle: assert property (@(posedge clk) disable iff (!rst_n)
        o_ready |-> (state_q == lt_pkg::FS_IDLE));

    // peripherals answer only what they were asked
    a_ram_rdy_en: assert property (@(posedge clk) disable iff (!rst_n)
        i_ram_rsp.ready |-> o_ram_en);
    a_tmr_rdy_en: assert property (@(posedge clk) disable iff (!rst_n)
        i_tmr_rsp.ready |-> o_tmr_en);

endmodule

//--- hw/lt_pkg.sv
package lt_pkg;

    // ------------------------------------------------------------------
    // bus widths
    // ------------------------------------------------------------------
    localparam int DATA_W    = 32;
    localparam int ADDR_W    = 32;
    localparam int BE_W      = DATA_W / 8;
    // top address bits pick the peripheral slot
    localparam int SLOT_W    = 4;
    localparam int OFFS_W    = ADDR_W - SLOT_W;
    // default ram depth in words
    localparam int RAM_WORDS = 256;
    // timer register offsets fit in the low 5 bits
    localparam int TREG_W    = 5;

    // ------------------------------------------------------------------
    // bus payloads
    // ------------------------------------------------------------------
    // request as the cpu presents it
    typedef struct packed {
        logic              write;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
        logic [BE_W-1:0]   be;
    } cpu_req_t;

    // request after slot strip, shared by all peripherals
    typedef struct packed {
        logic              write;
        logic [OFFS_W-1:0] offs;
        logic [DATA_W-1:0] wdata;
        logic [BE_W-1:0]   be;
    } per_req_t;

    // ready is a one-cycle pulse
    typedef struct packed {
        logic              ready;
        logic [DATA_W-1:0] rdata;
        logic              err;
    } per_rsp_t;

    // ------------------------------------------------------------------
    // encodings
    // ------------------------------------------------------------------
    typedef enum logic [SLOT_W-1:0] {
        SLOT_RAM   = 4'h0,
        SLOT_TIMER = 4'h1,
        // uart slot kept reserved, nothing mapped there
        SLOT_UART  = 4'h2
    } slot_e;

    typedef enum logic {
        FS_IDLE = 1'b0,
        FS_WAIT = 1'b1
    } fabric_state_e;

    typedef enum logic [TREG_W-1:0] {
        TR_CTRL    = 5'h00,
        TR_PERIOD  = 5'h04,
        TR_COMPARE = 5'h08,
        TR_COUNT   = 5'h0C,
        TR_STATUS  = 5'h10
    } timer_reg_e;

    // byte lanes of new_word replace those of old_word where be is set
    function automatic logic [DATA_W-1:0] be_merge(
        input logic [DATA_W-1:0] old_word,
        input logic [DATA_W-1:0] new_word,
        input logic [BE_W-1:0]   be
    );
        logic [DATA_W-1:0] merged;
        merged = old_word;
        for (int b = 0; b < BE_W; b++) begin
            if (be[b]) begin
                merged[8*b +: 8] = new_word[8*b +: 8];
            end
        end
        return merged;
    endfunction

endpackage

//--- hw/lt_soc_top.sv
`timescale 1ns/1ps

module lt_soc_top (
    input  logic                      clk,
    input  logic                      rst_n,
    // cpu bus
    input  logic                      i_enable,
    input  lt_pkg::cpu_req_t          i_req,
    output logic                      o_ready,
    output logic [lt_pkg::DATA_W-1:0] o_rdata,
    output logic                      o_bus_err,
    // timer pins
    output logic                      o_irq,
    output logic                      o_pwm
);

    // ------------------------------------------------------------------
    // fabric to peripheral wiring
    // ------------------------------------------------------------------
    lt_pkg::per_req_t per_req;
    logic             ram_en;
    logic             tmr_en;
    lt_pkg::per_rsp_t ram_rsp;
    lt_pkg::per_rsp_t tmr_rsp;

    lt_bus_fabric fab0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .i_enable  (i_enable),
        .i_req     (i_req),
        .o_ready   (o_ready),
        .o_rdata   (o_rdata),
        .o_bus_err (o_bus_err),
        .o_per_req (per_req),
        .o_ram_en  (ram_en),
        .o_tmr_en  (tmr_en),
        .i_ram_rsp (ram_rsp),
        .i_tmr_rsp (tmr_rsp)
    );

    // slot 0
    lt_sram #(
        .DEPTH_WORDS (lt_pkg::RAM_WORDS)
    ) ram0 (
        .clk   (clk),
        .rst_n (rst_n),
        .i_en  (ram_en),
        .i_req (per_req),
        .o_rsp (ram_rsp)
    );

    // slot 1
    lt_timer tmr0 (
        .clk   (clk),
        .rst_n (rst_n),
        .i_en  (tmr_en),
        .i_req (per_req),
        .o_rsp (tmr_rsp),
        .o_irq (o_irq),
        .o_pwm (o_pwm)
    );

endmodule

//--- hw/lt_sram.sv
`timescale 1ns/1ps

module lt_sram #(
    parameter int DEPTH_WORDS = lt_pkg::RAM_WORDS
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             i_en,
    input  lt_pkg::per_req_t i_req,
    output lt_pkg::per_rsp_t o_rsp
);

    localparam int IDX_W = (DEPTH_WORDS > 1) ? $clog2(DEPTH_WORDS) : 1;
    localparam logic [lt_pkg::OFFS_W-3:0] DEPTH_LIM = (lt_pkg::OFFS_W-2)'(DEPTH_WORDS);

    logic [lt_pkg::DATA_W-1:0] mem [DEPTH_WORDS];
    logic [lt_pkg::OFFS_W-3:0] word;
    logic [IDX_W-1:0]          idx;
    logic                      acc;
    logic                      ok;
    logic                      rsp_ready;
    logic [lt_pkg::DATA_W-1:0] rsp_rdata;
    logic                      rsp_err;

    // one access per enable, ignored while answering
    assign acc  = i_en && !rsp_ready;
    assign word = i_req.offs[lt_pkg::OFFS_W-1:2];
    assign idx  = word[IDX_W-1:0];
    // word aligned and inside the array
    assign ok   = (i_req.offs[1:0] == 2'b00) && (word < DEPTH_LIM);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rsp_ready <= 1'b0;
        end else begin
            rsp_ready <= acc;
        end
    end

    // storage and read path
    always_ff @(posedge clk) begin
        if (acc) begin
            rsp_err   <= !ok;
            rsp_rdata <= ok ? mem[idx] : '0;
            if (ok && i_req.write) begin
                mem[idx] <= lt_pkg::be_merge(mem[idx], i_req.wdata, i_req.be);
            end
        end
    end

    assign o_rsp = '{ready: rsp_ready, rdata: rsp_rdata, err: rsp_err};

    // ready is a pulse, never stretched
    a_ready_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        o_rsp.ready |=> !o_rsp.ready);

endmodule

//--- hw/lt_timer.sv
`timescale 1ns/1ps

module lt_timer (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             i_en,
    input  lt_pkg::per_req_t i_req,
    output lt_pkg::per_rsp_t o_rsp,
    output logic             o_irq,
    output logic             o_pwm
);

    // ctrl bit 0 run, bit 1 irq enable
    logic [1:0]                ctrl_q, ctrl_d;
    logic [lt_pkg::DATA_W-1:0] period_q, period_d;
    logic [lt_pkg::DATA_W-1:0] compare_q, compare_d;
    logic [lt_pkg::DATA_W-1:0] count_q, count_d;
    logic                      pend_q, pend_d;
    logic                      pwm_q;

    lt_pkg::timer_reg_e        reg_sel;
    logic                      acc;
    logic                      hi_zero;
    logic                      bad;
    logic                      wr_ok;
    logic [lt_pkg::DATA_W-1:0] rd_word;
    logic                      rsp_ready;
    logic [lt_pkg::DATA_W-1:0] rsp_rdata;
    logic                      rsp_err;

    // ------------------------------------------------------------------
    // register decode
    // ------------------------------------------------------------------
    assign acc     = i_en && !rsp_ready;
    assign hi_zero = (i_req.offs[lt_pkg::OFFS_W-1:lt_pkg::TREG_W] == '0);
    assign reg_sel = lt_pkg::timer_reg_e'(i_req.offs[lt_pkg::TREG_W-1:0]);

    always_comb begin
        rd_word = '0;
        bad     = 1'b1;
        if (hi_zero) begin
            case (reg_sel)
                lt_pkg::TR_CTRL: begin
                    rd_word = {{(lt_pkg::DATA_W-2){1'b0}}, ctrl_q};
                    bad     = 1'b0;
                end
                lt_pkg::TR_PERIOD: begin
                    rd_word = period_q;
                    bad     = 1'b0;
                end
                lt_pkg::TR_COMPARE: begin
                    rd_word = compare_q;
                    bad     = 1'b0;
                end
                lt_pkg::TR_COUNT: begin
                    // read only
                    rd_word = count_q;
                    bad     = i_req.write;
                end
                lt_pkg::TR_STATUS: begin
                    rd_word = {{(lt_pkg::DATA_W-1){1'b0}}, pend_q};
                    bad     = 1'b0;
                end
                default: ;
            endcase
        end
    end

    assign wr_ok = acc && i_req.write && !bad;

    // ------------------------------------------------------------------
    // next state
    // ------------------------------------------------------------------
    always_comb begin
        ctrl_d    = ctrl_q;
        period_d  = period_q;
        compare_d = compare_q;
        count_d   = count_q;
        pend_d    = pend_q;

        if (wr_ok && reg_sel == lt_pkg::TR_CTRL && i_req.be[0]) begin
            ctrl_d = i_req.wdata[1:0];
        end
        if (wr_ok && reg_sel == lt_pkg::TR_PERIOD) begin
            period_d = lt_pkg::be_merge(period_q, i_req.wdata, i_req.be);
        end
        if (wr_ok && reg_sel == lt_pkg::TR_COMPARE) begin
            compare_d = lt_pkg::be_merge(compare_q, i_req.wdata, i_req.be);
        end
        // write one to clear
        if (wr_ok && reg_sel == lt_pkg::TR_STATUS && i_req.be[0] && i_req.wdata[0]) begin
            pend_d = 1'b0;
        end

        // counter, a wrap in the same cycle beats the clear
        if (ctrl_q[0]) begin
            if (count_q >= period_q) begin
                count_d = '0;
                pend_d  = 1'b1;
            end else begin
                count_d = count_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ctrl_q    <= '0;
            period_q  <= '0;
            compare_q <= '0;
            count_q   <= '0;
            pend_q    <= 1'b0;
            pwm_q     <= 1'b0;
            rsp_ready <= 1'b0;
        end else begin
            ctrl_q    <= ctrl_d;
            period_q  <= period_d;
            compare_q <= compare_d;
            count_q   <= count_d;
            pend_q    <= pend_d;
            // follows the new state so pwm drops with the run bit
            pwm_q     <= ctrl_d[0] && (count_d < compare_d);
            rsp_ready <= acc;
        end
    end

    // response payload
    always_ff @(posedge clk) begin
        if (acc) begin
            rsp_rdata <= rd_word;
            rsp_err   <= bad;
        end
    end

    assign o_rsp = '{ready: rsp_ready, rdata: rsp_rdata, err: rsp_err};
    assign o_irq = pend_q && ctrl_q[1];
    assign o_pwm = pwm_q;

    a_pwm_stopped: assert property (@(posedge clk) disable iff (!rst_n)
        !ctrl_q[0] |-> !o_pwm);

endmodule

//--- run_sim.sh
#!/bin/sh
# build and run the subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_lt_soc \
    -f verilog.f \
    || { echo "build failed"; exit 1; }

out=$(./obj_dir/Vtb_lt_soc 2>&1)
printf '%s\n' "$out"

printf '%s\n' "$out" | grep -q "Testbench passed" \
    && echo "simulation ok" \
    || { echo "simulation failed"; exit 1; }

//--- sim/tb_lt_vectors.svh
`ifndef TB_LT_VECTORS_SVH
`define TB_LT_VECTORS_SVH

// row fields in order are name, write, addr, wdata, be, rdata check flag,
// expected rdata and expected err
typedef struct packed {
    logic                      write;
    logic [lt_pkg::ADDR_W-1:0] addr;
    logic [lt_pkg::DATA_W-1:0] wdata;
    logic [3:0]                be;
    logic                      chk_rd;
    logic [lt_pkg::DATA_W-1:0] exp_rdata;
    logic                      exp_err;
} vec_t;

vec_t  vec_q[$];
string name_q[$];

task automatic add_row(input string name, input logic wr, input logic [31:0] addr,
                       input logic [31:0] wdata, input logic [3:0] be, input logic chk,
                       input logic [31:0] exp_rd, input logic exp_err);
    vec_q.push_back('{write: wr, addr: addr, wdata: wdata, be: be, chk_rd: chk,
                      exp_rdata: exp_rd, exp_err: exp_err});
    name_q.push_back(name);
endtask

task automatic load_vectors();
    logic [31:0] rnd [5];
    logic [31:0] w1_merged;
    logic [31:0] w255_merged;
    // random ram data drawn after the seed is set
    for (int i = 0; i < 5; i++) begin
        rnd[i] = $urandom;
    end
    w1_merged   = merge_bytes(rnd[1], rnd[3], 4'b0101);
    w255_merged = merge_bytes(rnd[2], rnd[4], 4'b1000);

    // --------------------------------------------------------------------
    // ram full words at the first, second and last word
    // --------------------------------------------------------------------
    add_row("ram_wr_w0",    1, 32'h0000_0000, rnd[0], 4'hF, 0, 32'h0, 0);
    add_row("ram_wr_w1",    1, 32'h0000_0004, rnd[1], 4'hF, 0, 32'h0, 0);
    add_row("ram_wr_w255",  1, 32'h0000_03FC, rnd[2], 4'hF, 0, 32'h0, 0);
    add_row("ram_rd_w0",    0, 32'h0000_0000, 32'h0,  4'hF, 1, rnd[0], 0);
    add_row("ram_rd_w1",    0, 32'h0000_0004, 32'h0,  4'hF, 1, rnd[1], 0);
    add_row("ram_rd_w255",  0, 32'h0000_03FC, 32'h0,  4'hF, 1, rnd[2], 0);
    // byte lanes
    add_row("ram_be_w1",    1, 32'h0000_0004, rnd[3], 4'b0101, 0, 32'h0, 0);
    add_row("ram_be_rd_w1", 0, 32'h0000_0004, 32'h0,  4'hF, 1, w1_merged, 0);
    add_row("ram_be_w255",  1, 32'h0000_03FC, rnd[4], 4'b1000, 0, 32'h0, 0);
    add_row("ram_be_rd255", 0, 32'h0000_03FC, 32'h0,  4'hF, 1, w255_merged, 0);

    // --------------------------------------------------------------------
    // error answers and read backs of the stored words
    // --------------------------------------------------------------------
    add_row("slot2_wr",     1, 32'h2000_0000, 32'hDEAD_BEEF, 4'hF, 1, 32'h0, 1);
    add_row("slot7_rd",     0, 32'h7000_0010, 32'h0, 4'hF, 1, 32'h0, 1);
    // word 256 aliases word 0 if the range check is missing
    add_row("ram_past_end", 1, 32'h0000_0400, 32'hBAD0_0001, 4'hF, 0, 32'h0, 1);
    add_row("ram_rd_w0_ok", 0, 32'h0000_0000, 32'h0, 4'hF, 1, rnd[0], 0);
    add_row("ram_unalign",  1, 32'h0000_0006, 32'hBAD0_0002, 4'hF, 0, 32'h0, 1);
    add_row("ram_rd_w1_ok", 0, 32'h0000_0004, 32'h0, 4'hF, 1, w1_merged, 0);

    // --------------------------------------------------------------------
    // timer registers with the counter stopped
    // --------------------------------------------------------------------
    add_row("tmr_count_0",  0, 32'h1000_000C, 32'h0, 4'hF, 1, 32'h0, 0);
    add_row("tmr_wr_per",   1, 32'h1000_0004, 32'h64, 4'hF, 0, 32'h0, 0);
    add_row("tmr_wr_cmp",   1, 32'h1000_0008, 32'h20, 4'hF, 0, 32'h0, 0);
    add_row("tmr_wr_ctrl",  1, 32'h1000_0000, 32'h2, 4'hF, 0, 32'h0, 0);
    add_row("tmr_rd_per",   0, 32'h1000_0004, 32'h0, 4'hF, 1, 32'h64, 0);
    add_row("tmr_rd_cmp",   0, 32'h1000_0008, 32'h0, 4'hF, 1, 32'h20, 0);
    add_row("tmr_rd_ctrl",  0, 32'h1000_0000, 32'h0, 4'hF, 1, 32'h2, 0);
    add_row("tmr_unknown",  1, 32'h1000_0014, 32'h55, 4'hF, 0, 32'h0, 1);
    add_row("tmr_wr_count", 1, 32'h1000_000C, 32'h77, 4'hF, 0, 32'h0, 1);
    add_row("tmr_count_ok", 0, 32'h1000_000C, 32'h0, 4'hF, 1, 32'h0, 0);
    add_row("tmr_per_ok",   0, 32'h1000_0004, 32'h0, 4'hF, 1, 32'h64, 0);
endtask

`endif

//--- sim/tb_lt_soc.sv
`timescale 1ns/1ps

module tb_lt_soc;

    logic                      clk;
    logic                      rst_n;
    logic                      i_enable;
    lt_pkg::cpu_req_t          i_req;
    logic                      o_ready;
    logic [lt_pkg::DATA_W-1:0] o_rdata;
    logic                      o_bus_err;
    logic                      o_irq;
    logic                      o_pwm;

    int n_err;
    int n_tests;
    int n_failed;

    lt_soc_top dut0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .i_enable  (i_enable),
        .i_req     (i_req),
        .o_ready   (o_ready),
        .o_rdata   (o_rdata),
        .o_bus_err (o_bus_err),
        .o_irq     (o_irq),
        .o_pwm     (o_pwm)
    );

    // byte merge built from a lane mask
    function automatic logic [31:0] merge_bytes(input logic [31:0] old_w,
                                                input logic [31:0] new_w,
                                                input logic [3:0] be);
        logic [31:0] mask;
        mask = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
        return (old_w & ~mask) | (new_w & mask);
    endfunction

    `include "tb_lt_vectors.svh"

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        if (exp !== act) begin
            $display("ERROR %s: expected %h, actual %h", name, exp, act);
            n_err++;
        end
    endtask

    task automatic end_test(input string name, input int errs_before);
        n_tests++;
        if (n_err == errs_before) begin
            $display("PASS %s", name);
        end else begin
            $display("FAIL %s", name);
            n_failed++;
        end
    endtask

    // --------------------------------------------------------------------
    // cpu side handshake
    // --------------------------------------------------------------------
    task automatic bus_xfer(input logic wr, input logic [31:0] addr,
                            input logic [31:0] wdata, input logic [3:0] be,
                            output logic [31:0] rdata, output logic err);
        int waited;
        @(posedge clk);
        #1;
        i_req    = '{write: wr, addr: addr, wdata: wdata, be: be};
        i_enable = 1'b1;
        waited   = 0;
        while (!o_ready && waited < 20) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (!o_ready) begin
            $display("timeout: no ready from the bus at address %h", addr);
            n_err++;
        end
        rdata    = o_rdata;
        err      = o_bus_err;
        i_enable = 1'b0;
        // ready is held until the fabric sees enable low
        waited = 0;
        while (o_ready && waited < 20) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (o_ready) begin
            $display("timeout: ready stayed high after enable was dropped");
            n_err++;
        end
    endtask

    task automatic tmr_write(input string name, input logic [4:0] offs,
                             input logic [31:0] data);
        logic [31:0] rd;
        logic        er;
        bus_xfer(1'b1, {4'h1, 23'h0, offs}, data, 4'hF, rd, er);
        check_value({name, ".err"}, 32'h0, 32'(er));
    endtask

    // high samples of pwm over 30 cycles
    task automatic count_pwm(output int highs);
        highs = 0;
        for (int c = 0; c < 30; c++) begin
            @(posedge clk);
            #1;
            if (o_pwm) begin
                highs++;
            end
        end
    endtask

    // --------------------------------------------------------------------
    // main sequence
    // --------------------------------------------------------------------
    initial begin
        logic [31:0] rd;
        logic        er;
        int          start;
        int          waited;
        int          highs;

        n_err    = 0;
        n_tests  = 0;
        n_failed = 0;
        rst_n    = 1'b0;
        i_enable = 1'b0;
        i_req    = '0;
        void'($urandom(32'h72ae2b5a));
        load_vectors();

        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // table driven bus accesses
        for (int i = 0; i < vec_q.size(); i++) begin
            start = n_err;
            bus_xfer(vec_q[i].write, vec_q[i].addr, vec_q[i].wdata, vec_q[i].be, rd, er);
            check_value({name_q[i], ".err"}, 32'(vec_q[i].exp_err), 32'(er));
            if (vec_q[i].chk_rd) begin
                check_value(name_q[i], vec_q[i].exp_rdata, rd);
            end
            end_test(name_q[i], start);
        end

        // wrap interrupt
        start = n_err;
        tmr_write("irq_per", 5'h04, 32'd5);
        tmr_write("irq_ctrl", 5'h00, 32'h3);
        waited = 0;
        while (!o_irq && waited < 50) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (!o_irq) begin
            $display("timeout: irq did not rise with the timer running");
            n_err++;
        end
        bus_xfer(1'b0, 32'h1000_0010, 32'h0, 4'hF, rd, er);
        check_value("irq_status", 32'h1, rd);
        check_value("irq_status.err", 32'h0, 32'(er));
        // counter stopped first so no later wrap sets the flag again
        tmr_write("irq_stop", 5'h00, 32'h2);
        tmr_write("irq_clear", 5'h10, 32'h1);
        @(posedge clk);
        #1;
        check_value("irq_low", 32'h0, 32'(o_irq));
        bus_xfer(1'b0, 32'h1000_0010, 32'h0, 4'hF, rd, er);
        check_value("irq_status_clr", 32'h0, rd);
        end_test("timer_irq", start);

        // pwm at three compare values with period 9
        start = n_err;
        tmr_write("pwm_per", 5'h04, 32'd9);
        tmr_write("pwm_cmp0", 5'h08, 32'd0);
        tmr_write("pwm_run", 5'h00, 32'h1);
        count_pwm(highs);
        check_value("pwm_cmp0_highs", 32'd0, 32'(highs));
        end_test("pwm_low", start);

        start = n_err;
        tmr_write("pwm_cmp20", 5'h08, 32'd20);
        count_pwm(highs);
        check_value("pwm_cmp20_highs", 32'd30, 32'(highs));
        end_test("pwm_high", start);

        start = n_err;
        tmr_write("pwm_cmp4", 5'h08, 32'd4);
        count_pwm(highs);
        check_value("pwm_cmp4_toggles", 32'h1, 32'(highs > 0 && highs < 30));
        tmr_write("pwm_stop", 5'h00, 32'h0);
        @(posedge clk);
        #1;
        check_value("pwm_stopped", 32'h0, 32'(o_pwm));
        end_test("pwm_mixed", start);

        $display("tests run %0d, tests failed %0d, errors %0d", n_tests, n_failed, n_err);
        if (n_err == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

//--- verilog.f
+incdir+sim
hw/lt_pkg.sv
hw/lt_bus_fabric.sv
hw/lt_sram.sv
hw/lt_timer.sv
hw/lt_soc_top.sv
sim/tb_lt_soc.sv
